// File: flist.f
+incdir+.
game_pkg.sv
game_master_fsm.sv
game_sprite.sv
sprite_collision.sv
end_of_game_timer.sv
game_top.sv
tb_game_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it into sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_game_top -f flist.f -o sim_game
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_game > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0

// File: tb_game_top.sv
`timescale 1ns/1ps

`include "game_cfg.svh"

module tb_game_top
    import game_pkg::*;
();

    // tick budget per game: frames of play plus the held result.
    localparam int TEST_TICKS = (31 + 6) + (16 + 17 + 6) + (9 + 6) + 5;
    localparam int TIMEOUT_NS = (TEST_TICKS * 5 + 200) * 20;

    logic   clk;
    logic   reset;
    logic   key;
    logic   frame_tick;
    vel_t   target_dx;
    vel_t   torpedo_dy;
    coord_t target_x;
    coord_t target_y;
    coord_t torpedo_x;
    coord_t torpedo_y;
    logic   game_won;
    logic   end_of_game_timer_running;

    int   m_tx;                                     // expected target position.
    int   m_ty;
    int   m_px;                                     // expected torpedo position.
    int   m_py;
    int   m_tdx;
    int   m_pdy;
    int   m_timer;                                  // result frames still to hold.
    logic m_playing;
    logic m_launched;
    logic m_won;

    game_top game_top_inst
    (
        .clk                       (clk),
        .reset                     (reset),
        .key                       (key),
        .frame_tick                (frame_tick),
        .target_dx                 (target_dx),
        .torpedo_dy                (torpedo_dy),
        .target_x                  (target_x),
        .target_y                  (target_y),
        .torpedo_x                 (torpedo_x),
        .torpedo_y                 (torpedo_y),
        .game_won                  (game_won),
        .end_of_game_timer_running (end_of_game_timer_running)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t expected);
        if (got !== expected)
        begin
            $display("error: time %0t, %s = %0d, expected %0d", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("error: time %0t, %s = %b, expected %b", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    // the whole box has to fit in the visible area.
    function automatic logic on_screen(input int x, input int y);
        return x >= 0 && x + `SPRITE_W <= `SCREEN_W && y >= 0 && y + `SPRITE_H <= `SCREEN_H;
    endfunction

    function automatic logic boxes_overlap(input int ax, input int ay, input int bx, input int by);
        return ax < bx + `SPRITE_W && bx < ax + `SPRITE_W
            && ay < by + `SPRITE_H && by < ay + `SPRITE_H;
    endfunction

    // earliest number of target frames before launch that ends in a hit.
    function automatic int find_launch_tick(input int dx, input int dy);
        int tx;
        int py;
        for (int k = 0; k < 40; k++)
        begin
            tx = `TARGET_X0;
            py = `TORPEDO_Y0;
            for (int n = 1; on_screen(tx, `TARGET_Y0) && on_screen(`TORPEDO_X0, py); n++)
            begin
                tx = tx + dx;
                if (n > k)
                    py = py + dy;
                if (n > k && boxes_overlap(tx, `TARGET_Y0, `TORPEDO_X0, py))
                    return k;
            end
        end
        return -1;
    endfunction

    task automatic model_restart();
        m_tx       = `TARGET_X0;
        m_ty       = `TARGET_Y0;
        m_px       = `TORPEDO_X0;
        m_py       = `TORPEDO_Y0;
        m_tdx      = target_dx;                     // sampled when the game reloads.
        m_pdy      = 0;
        m_timer    = 0;
        m_playing  = 1'b1;
        m_launched = 1'b0;
        m_won      = 1'b0;
    endtask

    task automatic model_frame();
        logic hit;
        if (m_playing)
        begin
            m_tx = m_tx + m_tdx;
            if (m_launched)
                m_py = m_py + m_pdy;
            hit = boxes_overlap(m_tx, m_ty, m_px, m_py);
            if (!on_screen(m_tx, m_ty) || !on_screen(m_px, m_py) || (m_launched && hit))
            begin
                m_playing = 1'b0;
                m_won     = hit;                    // sprites freeze with the result.
                m_timer   = `END_TIMER_TICKS;
            end
        end
        else if (m_timer > 0)
        begin
            m_timer = m_timer - 1;
            if (m_timer == 0)
                model_restart();
        end
    endtask

    task automatic check_state();
        check_coord("target_x", target_x, coord_t'(m_tx));
        check_coord("target_y", target_y, coord_t'(m_ty));
        check_coord("torpedo_x", torpedo_x, coord_t'(m_px));
        check_coord("torpedo_y", torpedo_y, coord_t'(m_py));
        check_flag("game_won", game_won, m_won);
        check_flag("end_of_game_timer_running", end_of_game_timer_running, m_timer != 0);
    endtask

    // one frame strobe, then enough idle cycles for the control to settle.
    task automatic frame_step();
        frame_tick = 1'b1;
        @(negedge clk);
        frame_tick = 1'b0;
        repeat (4) @(negedge clk);
        model_frame();
        check_state();
    endtask

    task automatic launch_torpedo(input int dy);
        torpedo_dy = vel_t'(dy);
        key        = 1'b1;
        @(negedge clk);
        key = 1'b0;
        @(negedge clk);
        m_launched = 1'b1;
        m_pdy      = dy;
    endtask

    task automatic test_reset_state();
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        model_restart();
        check_state();
    endtask

    task automatic test_no_key();
        while (m_playing)
            frame_step();
    endtask

    task automatic wait_restart(input int next_dx);
        target_dx = vel_t'(next_dx);
        repeat (`END_TIMER_TICKS) frame_step();
    endtask

    task automatic test_hit();
        int k;
        k = find_launch_tick(m_tdx, -2);
        if (k < 0)
        begin
            $display("no launch frame gives a hit for target_dx %0d", m_tdx);
            stop_with_failure();
        end
        repeat (k) frame_step();
        launch_torpedo(-2);
        while (m_playing)
            frame_step();
    endtask

    // a steep climb passes the target row before any target speed can reach the torpedo column.
    task automatic test_miss();
        launch_torpedo(-5);
        while (m_playing)
            frame_step();
        if (m_won || m_py >= 0)
        begin
            $display("the torpedo was expected to leave the top of the screen");
            stop_with_failure();
        end
    endtask

    task automatic test_second_game();
        repeat (5) frame_step();
    endtask

    initial
    begin
        void'($urandom(37548));
        reset      = 1'b1;
        key        = 1'b0;
        frame_tick = 1'b0;
        target_dx  = vel_t'(2);
        torpedo_dy = '0;
        test_reset_state();
        test_no_key();
        wait_restart(1);
        test_hit();
        wait_restart(1 + $urandom % 3);
        test_miss();
        wait_restart(1 + $urandom % 3);
        test_second_game();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: game_top.sv
`timescale 1ns/1ps

`include "game_cfg.svh"

module game_top
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   key,
    input  logic   frame_tick,
    input  vel_t   target_dx,
    input  vel_t   torpedo_dy,
    output coord_t target_x,
    output coord_t target_y,
    output coord_t torpedo_x,
    output coord_t torpedo_y,
    output logic   game_won,
    output logic   end_of_game_timer_running
);

    logic sprite_target_write_xy;
    logic sprite_torpedo_write_xy;
    logic sprite_target_write_dxy;
    logic sprite_torpedo_write_dxy;
    logic sprite_target_enable_update;
    logic sprite_torpedo_enable_update;
    logic sprite_target_within_screen;
    logic sprite_torpedo_within_screen;
    logic collision;
    logic end_of_game_timer_start;

    game_master_fsm game_master_fsm_inst
    (
        .clk                          (clk),
        .reset                        (reset),
        .key                          (key),
        .sprite_target_write_xy       (sprite_target_write_xy),
        .sprite_torpedo_write_xy      (sprite_torpedo_write_xy),
        .sprite_target_write_dxy      (sprite_target_write_dxy),
        .sprite_torpedo_write_dxy     (sprite_torpedo_write_dxy),
        .sprite_target_enable_update  (sprite_target_enable_update),
        .sprite_torpedo_enable_update (sprite_torpedo_enable_update),
        .sprite_target_within_screen  (sprite_target_within_screen),
        .sprite_torpedo_within_screen (sprite_torpedo_within_screen),
        .collision                    (collision),
        .end_of_game_timer_start      (end_of_game_timer_start),
        .game_won                     (game_won),
        .end_of_game_timer_running    (end_of_game_timer_running)
    );

    // the target only flies sideways.
    game_sprite #(.start_x(coord_t'(`TARGET_X0)), .start_y(coord_t'(`TARGET_Y0))) sprite_target_inst
    (
        .clk           (clk),
        .reset         (reset),
        .write_xy      (sprite_target_write_xy),
        .write_dxy     (sprite_target_write_dxy),
        .enable_update (sprite_target_enable_update),
        .frame_tick    (frame_tick),
        .dx            (target_dx),
        .dy            (vel_t'(0)),
        .x             (target_x),
        .y             (target_y),
        .within_screen (sprite_target_within_screen)
    );

    // the torpedo only flies vertically.
    game_sprite #(.start_x(coord_t'(`TORPEDO_X0)), .start_y(coord_t'(`TORPEDO_Y0))) sprite_torpedo_inst
    (
        .clk           (clk),
        .reset         (reset),
        .write_xy      (sprite_torpedo_write_xy),
        .write_dxy     (sprite_torpedo_write_dxy),
        .enable_update (sprite_torpedo_enable_update),
        .frame_tick    (frame_tick),
        .dx            (vel_t'(0)),
        .dy            (torpedo_dy),
        .x             (torpedo_x),
        .y             (torpedo_y),
        .within_screen (sprite_torpedo_within_screen)
    );

    sprite_collision sprite_collision_inst
    (
        .clk       (clk),
        .reset     (reset),
        .target_x  (target_x),
        .target_y  (target_y),
        .torpedo_x (torpedo_x),
        .torpedo_y (torpedo_y),
        .collision (collision)
    );

    end_of_game_timer end_of_game_timer_inst
    (
        .clk        (clk),
        .reset      (reset),
        .start      (end_of_game_timer_start),
        .frame_tick (frame_tick),
        .running    (end_of_game_timer_running)
    );

endmodule

// File: end_of_game_timer.sv
`timescale 1ns/1ps

`include "game_cfg.svh"

module end_of_game_timer
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic frame_tick,
    output logic running
);

    localparam int CNT_W = $clog2(`END_TIMER_TICKS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= CNT_W'(`END_TIMER_TICKS);          // a new start wins over a tick.
        else if (frame_tick && count != '0)
            count <= count - 1'b1;
    end

    // high from the cycle after start until the last tick is counted.
    assign running = (count != '0);

endmodule

// File: sprite_collision.sv
`timescale 1ns/1ps

`include "game_cfg.svh"

module sprite_collision
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  coord_t target_x,
    input  coord_t target_y,
    input  coord_t torpedo_x,
    input  coord_t torpedo_y,
    output logic   collision
);

    logic overlap_x;
    logic overlap_y;

    // two ranges intersect when each one starts before the other ends.
    assign overlap_x = (target_x < torpedo_x + `SPRITE_W) && (torpedo_x < target_x + `SPRITE_W);
    assign overlap_y = (target_y < torpedo_y + `SPRITE_H) && (torpedo_y < target_y + `SPRITE_H);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap_x && overlap_y;        // valid one cycle after the positions.
    end

endmodule

// File: game_sprite.sv
`timescale 1ns/1ps

`include "game_cfg.svh"

module game_sprite
    import game_pkg::*;
#(
    parameter coord_t start_x = '0,
    parameter coord_t start_y = '0
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   write_xy,
    input  logic   write_dxy,
    input  logic   enable_update,
    input  logic   frame_tick,
    input  vel_t   dx,
    input  vel_t   dy,
    output coord_t x,
    output coord_t y,
    output logic   within_screen
);

    vel_t vx;
    vel_t vy;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x <= start_x;
            y <= start_y;
        end
        else if (write_xy)
        begin
            x <= start_x;
            y <= start_y;
        end
        else if (enable_update && frame_tick)
        begin
            x <= x + vx;                                // velocity is sign extended.
            y <= y + vy;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            vx <= '0;
            vy <= '0;
        end
        else if (write_dxy)
        begin
            vx <= dx;
            vy <= dy;
        end
        else if (write_xy)
        begin
            vx <= '0;                                   // a reload without a velocity parks it.
            vy <= '0;
        end
    end

    // the whole box must lie inside the visible area.
    assign within_screen = (x >= 0) && (x <= `SCREEN_W - `SPRITE_W)
                        && (y >= 0) && (y <= `SCREEN_H - `SPRITE_H);

    a_load_or_move : assert property (@(posedge clk) disable iff (reset)
        !(write_xy && enable_update));

endmodule

// File: game_master_fsm.sv
`timescale 1ns/1ps

module game_master_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic key,
    output logic sprite_target_write_xy,
    output logic sprite_torpedo_write_xy,
    output logic sprite_target_write_dxy,
    output logic sprite_torpedo_write_dxy,
    output logic sprite_target_enable_update,
    output logic sprite_torpedo_enable_update,
    input  logic sprite_target_within_screen,
    input  logic sprite_torpedo_within_screen,
    input  logic collision,
    output logic end_of_game_timer_start,
    output logic game_won,
    input  logic end_of_game_timer_running
);

    localparam int START_TARGET    = 0;
    localparam int WAIT_KEY        = 1;
    localparam int START_TORPEDO   = 2;
    localparam int WAIT_COLLISION  = 3;
    localparam int START_END_TIMER = 4;
    localparam int GAME_WON        = 5;
    localparam int GAME_LOST       = 6;
    localparam int N_STATES        = 7;

    logic [N_STATES-1:0] state;
    logic [N_STATES-1:0] state_next;
    logic                off_screen;
    logic                end_of_game;

    assign off_screen  = ~sprite_target_within_screen | ~sprite_torpedo_within_screen;
    assign end_of_game = off_screen | collision;

    always_comb
    begin
        state_next = '0;
        case (1'b1)
            state[START_TARGET]:
                state_next[WAIT_KEY] = 1'b1;
            state[WAIT_KEY]:
            begin
                // collision may still hold the last game's hit for one cycle after
                // the reload, and a parked torpedo cannot be hit anyway.
                if (key)
                    state_next[START_TORPEDO] = 1'b1;
                else if (off_screen)
                    state_next[START_END_TIMER] = 1'b1;
                else
                    state_next[WAIT_KEY] = 1'b1;
            end
            state[START_TORPEDO]:
                state_next[WAIT_COLLISION] = 1'b1;
            state[WAIT_COLLISION]:
            begin
                if (end_of_game)
                    state_next[START_END_TIMER] = 1'b1;
                else
                    state_next[WAIT_COLLISION] = 1'b1;
            end
            state[START_END_TIMER]:
            begin
                if (collision)                          // sprites are frozen, so it is stable.
                    state_next[GAME_WON] = 1'b1;
                else
                    state_next[GAME_LOST] = 1'b1;
            end
            state[GAME_WON]:
            begin
                if (end_of_game_timer_running)
                    state_next[GAME_WON] = 1'b1;
                else
                    state_next[START_TARGET] = 1'b1;
            end
            state[GAME_LOST]:
            begin
                if (end_of_game_timer_running)
                    state_next[GAME_LOST] = 1'b1;
                else
                    state_next[START_TARGET] = 1'b1;
            end
            default:
                state_next[START_TARGET] = 1'b1;        // recover from an illegal code.
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= N_STATES'(1) << START_TARGET;
        else
            state <= state_next;
    end

    assign sprite_target_write_xy       = state[START_TARGET];
    assign sprite_torpedo_write_xy      = state[START_TARGET];
    assign sprite_target_write_dxy      = state[START_TARGET];
    // the torpedo velocity tracks the switches until and during flight.
    assign sprite_torpedo_write_dxy     = state[WAIT_KEY] | state[WAIT_COLLISION];
    assign sprite_target_enable_update  = state[WAIT_KEY] | state[WAIT_COLLISION];
    assign sprite_torpedo_enable_update = state[WAIT_COLLISION];
    assign end_of_game_timer_start      = state[START_END_TIMER];
    assign game_won                     = state[GAME_WON];

    a_state_onehot : assert property (@(posedge clk) disable iff (reset) $onehot(state));

    // the timer must have expired before a new result can be started.
    a_start_idle : assert property (@(posedge clk) disable iff (reset)
        end_of_game_timer_start |-> !end_of_game_timer_running);

endmodule

// File: game_pkg.sv
package game_pkg;

    // a signed screen coordinate keeps its meaning after the sprite
    // has crossed the left or the top border.
    typedef logic signed [9:0] coord_t;

    // velocity in pixels per frame tick, negative moves left or up.
    typedef logic signed [3:0] vel_t;

endpackage

// File: game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Visible area, kept small so that a game fits in a short simulation.
`define SCREEN_W 64
`define SCREEN_H 48

`define SPRITE_W 4                  // box width of both sprites.
`define SPRITE_H 4                  // box height of both sprites.

// Start positions give the upper left corner of each box.
`define TARGET_X0 0                 // the target enters at the left edge.
`define TARGET_Y0 8
`define TORPEDO_X0 30               // the torpedo waits near the bottom middle.
`define TORPEDO_Y0 44

`define END_TIMER_TICKS 6           // frames that the result stays on screen.

`endif
